// File: Makefile
VERILATOR ?= verilator
TOP       := tb_rv32i_backend
FILELIST  := rv32i_backend.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
RUNFLAGS  := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/backend_checker.sv
`timescale 1ns/1ps
`default_nettype none

module backend_checker
    import rv32i_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       ex_valid_i,
    input  wire logic       ex_ready_i,
    input  ex_mem_t         ex_data_i,
    input  wire logic [2:0] test_id_i,
    input  wire logic       wb_valid_i,
    input  reg_addr_t       wb_rd_i,
    input  rv32i_word       wb_data_i,
    input  wire logic       readout_i,
    input  reg_addr_t       rs_addr_i,
    input  rv32i_word       rs_data_i,
    output int              wb_errors_o,
    output int              reg_errors_o,
    output int              other_errors_o,
    output int              pending_o
);

    typedef struct packed {
        logic [2:0] test;
        reg_addr_t  rd;
        rv32i_word  value;
    } expect_t;

    expect_t   exp_q [$];
    rv32i_word ram_model [ram_words];
    rv32i_word reg_model [num_regs];
    int        wb_errors = 0;
    int        reg_errors = 0;
    int        other_errors = 0;
    int        pending = 0;

    assign wb_errors_o    = wb_errors;
    assign reg_errors_o   = reg_errors;
    assign other_errors_o = other_errors;
    assign pending_o      = pending;

    initial begin
        for (int i = 0; i < ram_words; i++) begin
            ram_model[i] = '0;
        end
        for (int i = 0; i < num_regs; i++) begin
            reg_model[i] = '0;
        end
    end

    function automatic string test_name(logic [2:0] id);
        case (id)
            3'd1: return "alu_writeback";
            3'd2: return "word_access";
            3'd3: return "byte_access";
            3'd4: return "half_access";
            3'd5: return "random_stream";
            3'd6: return "no_write";
            default: return "reg_readout";
        endcase
    endfunction

    // writeback value given the ram word at the instruction's address
    function automatic rv32i_word expected_wb(ex_mem_t instr, rv32i_word word);
        logic [7:0]  b;
        logic [15:0] h;
        rv32i_word   v;
        b = 8'(word >> (8 * instr.alu_out[1:0]));
        h = 16'(word >> (16 * instr.alu_out[1]));
        case (instr.ctrl.regfilemux_sel)
            alu_out:  v = instr.alu_out;
            br_en:    v = 32'(instr.br_en);
            u_imm:    v = instr.u_imm;
            pc_plus4: v = instr.pc + 32'd4;
            lw:       v = word;
            lb:       v = (b[7] ? 32'hFFFF_FF00 : 32'h0) | 32'(b);
            lbu:      v = 32'(b);
            lh:       v = (h[15] ? 32'hFFFF_0000 : 32'h0) | 32'(h);
            lhu:      v = 32'(h);
            default:  v = instr.alu_out;
        endcase
        return v;
    endfunction

    function automatic rv32i_word merged_store(ex_mem_t instr, rv32i_word word);
        rv32i_word mask;
        rv32i_word data;
        int        shift;
        case (instr.ctrl.mem_size)
            size_byte: begin
                shift = 8 * instr.alu_out[1:0];
                mask  = 32'h0000_00FF << shift;
                data  = 32'(instr.store_data[7:0]) << shift;
            end
            size_half: begin
                shift = 16 * instr.alu_out[1];
                mask  = 32'h0000_FFFF << shift;
                data  = 32'(instr.store_data[15:0]) << shift;
            end
            default: begin
                mask = 32'hFFFF_FFFF;
                data = instr.store_data;
            end
        endcase
        return (word & ~mask) | (data & mask);
    endfunction

    always @(posedge clk_i) begin : compare
        expect_t              head;
        expect_t              entry;
        logic [ram_idx_w-1:0] idx;
        rv32i_word            value;
        if (rst_n_i) begin
            // retire before accept since the accepted one is always younger
            if (wb_valid_i) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("writeback to x%0d with %h while nothing is outstanding",
                             wb_rd_i, wb_data_i);
                end else begin
                    head = exp_q.pop_front();
                    if (wb_rd_i != head.rd) begin
                        wb_errors++;
                        $display("[ERROR] %s: rd expected x%0d actual x%0d",
                                 test_name(head.test), head.rd, wb_rd_i);
                    end
                    if (wb_data_i != head.value) begin
                        wb_errors++;
                        $display("[ERROR] %s: x%0d expected %h actual %h",
                                 test_name(head.test), head.rd, head.value, wb_data_i);
                    end
                end
            end
            if (ex_valid_i && ex_ready_i) begin
                idx = ex_data_i.alu_out[ram_idx_w+1:2];
                if (ex_data_i.ctrl.mem_op == mem_store) begin
                    ram_model[idx] = merged_store(ex_data_i, ram_model[idx]);
                end else if (ex_data_i.ctrl.load_regfile) begin
                    value       = expected_wb(ex_data_i, ram_model[idx]);
                    entry.test  = test_id_i;
                    entry.rd    = ex_data_i.rd;
                    entry.value = value;
                    exp_q.push_back(entry);
                    if (ex_data_i.rd != 5'd0) begin
                        reg_model[ex_data_i.rd] = value;
                    end
                end
            end
            if (readout_i && rs_data_i != reg_model[rs_addr_i]) begin
                reg_errors++;
                $display("[ERROR] reg_readout: x%0d expected %h actual %h",
                         rs_addr_i, reg_model[rs_addr_i], rs_data_i);
            end
            pending <= exp_q.size();
        end
    end

endmodule

`default_nettype wire

// File: bench/backend_props.sv
`timescale 1ns/1ps
`default_nettype none

module backend_props
    import rv32i_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  apb_req_t  apb_o,
    input  wire logic pready_i,
    input  wire logic ex_valid_i,
    input  wire logic ex_ready_o,
    input  ex_mem_t   ex_data_i
);

    int fail_count = 0;

    // one setup cycle then access
    setup_then_access: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        apb_o.psel && !apb_o.penable |=> apb_o.psel && apb_o.penable
    ) else begin
        fail_count++;
        $error("apb setup phase not followed by an access phase");
    end

    // request held until pready ends the access
    request_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        apb_o.psel && !(apb_o.penable && pready_i) |=>
            apb_o.psel && $stable(apb_o.pwrite) && $stable(apb_o.paddr) &&
            $stable(apb_o.pwdata) && $stable(apb_o.pstrb)
    ) else begin
        fail_count++;
        $error("apb request changed before pready");
    end

    stall_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ex_valid_i && !ex_ready_o |=> ex_valid_i && $stable(ex_data_i)
    ) else begin
        fail_count++;
        $error("upstream instruction dropped or changed while stalled");
    end

endmodule

`default_nettype wire

// File: bench/tb_rv32i_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_backend
    import rv32i_pkg::*;
();

    localparam int num_random = 200;
    localparam logic [31:0] seed = 32'he261_8072;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       ex_valid;
    ex_mem_t    ex_data;
    logic       ex_ready;
    reg_addr_t  rs_addr;
    rv32i_word  rs_data;
    logic       wb_valid;
    reg_addr_t  wb_rd;
    rv32i_word  wb_data;
    logic       readout;
    logic [2:0] test_id;
    int         issued = 0;
    int         cycles = 0;
    int         wb_errors;
    int         reg_errors;
    int         other_errors;
    int         pending;
    int         assert_errors;

    regfilemux_sel_t nonmem_sels [4] = '{alu_out, br_en, u_imm, pc_plus4};
    regfilemux_sel_t load_sels [5]   = '{lw, lb, lbu, lh, lhu};
    mem_size_t       sizes [3]       = '{size_byte, size_half, size_word};

    always #2 clk = ~clk;

    rv32i_backend uut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .ex_valid_i (ex_valid),
        .ex_data_i  (ex_data),
        .ex_ready_o (ex_ready),
        .rs_addr_i  (rs_addr),
        .rs_data_o  (rs_data),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data)
    );

    backend_checker u_checker (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .ex_valid_i     (ex_valid),
        .ex_ready_i     (ex_ready),
        .ex_data_i      (ex_data),
        .test_id_i      (test_id),
        .wb_valid_i     (wb_valid),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .readout_i      (readout),
        .rs_addr_i      (rs_addr),
        .rs_data_i      (rs_data),
        .wb_errors_o    (wb_errors),
        .reg_errors_o   (reg_errors),
        .other_errors_o (other_errors),
        .pending_o      (pending)
    );

    bind mem_stage backend_props u_props (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .apb_o      (apb_o),
        .pready_i   (pready_i),
        .ex_valid_i (ex_valid_i),
        .ex_ready_o (ex_ready_o),
        .ex_data_i  (ex_data_i)
    );

    assign assert_errors = uut.u_mem_stage.u_props.fail_count;

    function automatic mem_size_t load_size(regfilemux_sel_t sel);
        if (sel == lb || sel == lbu) begin
            return size_byte;
        end else if (sel == lh || sel == lhu) begin
            return size_half;
        end
        return size_word;
    endfunction

    function automatic ex_mem_t build_instr(regfilemux_sel_t sel, mem_op_t op,
                                            mem_size_t size, logic lr, reg_addr_t rd,
                                            rv32i_word addr, rv32i_word sdata);
        ex_mem_t instr;
        instr.ctrl.load_regfile   = lr;
        instr.ctrl.regfilemux_sel = sel;
        instr.ctrl.mem_op         = op;
        instr.ctrl.mem_size       = size;
        instr.rd                  = rd;
        instr.alu_out             = addr;
        instr.store_data          = sdata;
        instr.pc                  = $urandom & 32'hFFFF_FFFC;
        instr.u_imm               = $urandom & 32'hFFFF_F000;
        instr.br_en               = 1'($urandom);
        return instr;
    endfunction

    function automatic ex_mem_t random_instr();
        int               kind;
        regfilemux_sel_t  sel;
        reg_addr_t        rd;
        rv32i_word        addr;
        logic             lr;
        kind = $urandom_range(9);
        rd   = reg_addr_t'($urandom_range(31));
        // upper bits vary but only 16 words are hit
        addr = $urandom & 32'hFFFF_FC3F;
        lr   = ($urandom_range(7) != 0);
        if (kind < 3) begin
            sel = load_sels[$urandom_range(4)];
            return build_instr(sel, mem_load, load_size(sel), lr, rd, addr, '0);
        end else if (kind < 5) begin
            return build_instr(alu_out, mem_store, sizes[$urandom_range(2)], 1'b0, rd, addr,
                               $urandom);
        end
        return build_instr(nonmem_sels[$urandom_range(3)], mem_none, size_word, lr, rd,
                           $urandom, '0);
    endfunction

    // holds the instruction until the edge that accepts it
    task automatic issue(input ex_mem_t instr);
        logic taken;
        @(negedge clk);
        ex_valid = 1'b1;
        ex_data  = instr;
        taken    = 1'b0;
        while (!taken) begin
            taken = ex_ready;
            @(posedge clk);
            if (!taken) begin
                @(negedge clk);
            end
        end
        issued++;
    endtask

    task automatic pause(input int n);
        @(negedge clk);
        ex_valid = 1'b0;
        repeat (n - 1) @(negedge clk);
    endtask

    task automatic begin_test(input logic [2:0] id);
        @(negedge clk);
        ex_valid = 1'b0;
        test_id  = id;
    endtask

    task automatic store(input mem_size_t size, input rv32i_word addr, input rv32i_word data);
        issue(build_instr(alu_out, mem_store, size, 1'b0, 5'd0, addr, data));
    endtask

    task automatic load(input regfilemux_sel_t sel, input reg_addr_t rd, input rv32i_word addr);
        issue(build_instr(sel, mem_load, load_size(sel), 1'b1, rd, addr, '0));
    endtask

    task automatic drain();
        pause(1);
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
    endtask

    task automatic read_back_regs();
        for (int i = 0; i < num_regs; i++) begin
            @(negedge clk);
            readout = 1'b1;
            rs_addr = reg_addr_t'(i);
        end
        @(negedge clk);
        readout = 1'b0;
    endtask

    // limit grows with the work issued so far
    initial begin
        while (cycles <= 20 * issued + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d instructions issued", cycles, issued);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        ex_valid = 1'b0;
        ex_data  = '0;
        rs_addr  = '0;
        readout  = 1'b0;
        test_id  = 3'd0;
        void'($urandom(seed));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // rd 0 is hit twice
        begin_test(3'd1);
        for (int i = 0; i < 10; i++) begin
            issue(build_instr(nonmem_sels[i % 4], mem_none, size_word, 1'b1,
                              reg_addr_t'(i % 8), $urandom, '0));
        end

        begin_test(3'd2);
        for (int k = 0; k < 4; k++) begin
            store(size_word, 32'h100 + 4 * k, $urandom);
            load(lw, reg_addr_t'(10 + k), 32'h100 + 4 * k);
        end

        // lw after each byte store shows the neighbours
        begin_test(3'd3);
        store(size_word, 32'h200, 32'h1122_3344);
        for (int k = 0; k < 4; k++) begin
            store(size_byte, 32'h200 + k, (k % 2 == 1) ? 32'h5A : 32'hC3 + k);
            load(lw, 5'd22, 32'h200);
        end
        for (int k = 0; k < 4; k++) begin
            load(lb, reg_addr_t'(14 + k), 32'h200 + k);
            load(lbu, reg_addr_t'(18 + k), 32'h200 + k);
        end

        begin_test(3'd4);
        store(size_word, 32'h300, 32'hDEAD_BEEF);
        store(size_half, 32'h300, 32'h0000_8001);
        store(size_half, 32'h303, 32'h0000_7FFE);
        load(lh, 5'd23, 32'h300);
        load(lhu, 5'd24, 32'h300);
        load(lh, 5'd25, 32'h302);
        load(lhu, 5'd26, 32'h303);
        load(lw, 5'd27, 32'h300);

        begin_test(3'd6);
        for (int i = 0; i < 4; i++) begin
            issue(build_instr(alu_out, mem_none, size_word, 1'b0, reg_addr_t'(1 + i),
                              $urandom, '0));
        end
        issue(build_instr(lw, mem_load, size_word, 1'b0, 5'd5, 32'h100, '0));
        store(size_word, 32'h104, $urandom);
        load(lw, 5'd28, 32'h104);

        begin_test(3'd5);
        for (int i = 0; i < num_random; i++) begin
            issue(random_instr());
            if ($urandom_range(3) == 0) begin
                pause($urandom_range(3, 1));
            end
        end
        drain();

        begin_test(3'd7);
        read_back_regs();
        @(negedge clk);

        $display("errors: writeback %0d, register readout %0d, other %0d, assertions %0d",
                 wb_errors, reg_errors, other_errors, assert_errors);
        if (wb_errors + reg_errors + other_errors + assert_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import rv32i_pkg::*;
#(
    parameter logic [7:0] WAIT_CYCLES = 8'd1
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  apb_req_t  apb_i,
    output rv32i_word prdata_o,
    output logic      pready_o
);

    rv32i_word            mem [ram_words];
    logic [7:0]           wait_q;
    logic                 access;
    logic [ram_idx_w-1:0] idx;

    assign access   = apb_i.psel && apb_i.penable;
    assign idx      = apb_i.paddr[ram_idx_w+1:2];
    assign pready_o = access && (wait_q == WAIT_CYCLES);
    assign prdata_o = mem[idx];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q <= '0;
            for (int i = 0; i < ram_words; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // count wait states inside the access phase
            if (access && !pready_o) begin
                wait_q <= wait_q + 8'd1;
            end else begin
                wait_q <= '0;
            end
            // only strobed bytes change
            if (pready_o && apb_i.pwrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (apb_i.pstrb[b]) begin
                        mem[idx][8*b +: 8] <= apb_i.pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import rv32i_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic ex_valid_i,
    input  ex_mem_t   ex_data_i,
    output logic      ex_ready_o,
    output apb_req_t  apb_o,
    input  rv32i_word prdata_i,
    input  wire logic pready_i,
    output logic      wb_valid_o,
    output mem_wb_t   wb_data_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } mem_state_t;

    mem_state_t state_q;
    mem_state_t state_d;
    ex_mem_t    ex_q;
    mem_wb_t    wb_d;
    mem_wb_t    wb_q;
    logic       ready_q;
    logic       pend_q;
    logic       wb_valid_q;
    logic       accept;
    logic       is_mem;
    logic       wb_load;
    logic [1:0] lane;

    assign ex_ready_o = ready_q && (state_q == st_idle);
    assign accept     = ex_valid_i && ex_ready_o;
    assign is_mem     = ex_data_i.ctrl.mem_op != mem_none;
    assign lane       = ex_q.alu_out[1:0];

    // pend_q marks a non-memory instruction waiting in ex_q
    assign wb_load = (state_q == st_idle && pend_q) ||
                     (state_q == st_access && pready_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (accept && is_mem) begin
                    state_d = st_setup;
                end
            end
            st_setup: begin
                state_d = st_access;
            end
            st_access: begin
                if (pready_i) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // apb request held stable by ex_q until pready
    always_comb begin
        apb_o.psel    = state_q != st_idle;
        apb_o.penable = state_q == st_access;
        apb_o.pwrite  = ex_q.ctrl.mem_op == mem_store;
        apb_o.paddr   = {ex_q.alu_out[xlen-1:2], 2'b00};
        case (ex_q.ctrl.mem_size)
            size_byte: begin
                apb_o.pwdata = {4{ex_q.store_data[7:0]}};
                apb_o.pstrb  = 4'b0001 << lane;
            end
            size_half: begin
                apb_o.pwdata = {2{ex_q.store_data[15:0]}};
                apb_o.pstrb  = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                apb_o.pwdata = ex_q.store_data;
                apb_o.pstrb  = 4'b1111;
            end
        endcase
        // reads carry no strobes
        if (!apb_o.pwrite) begin
            apb_o.pstrb = 4'b0000;
        end
    end

    always_comb begin
        wb_d.ctrl      = ex_q.ctrl;
        wb_d.rd        = ex_q.rd;
        wb_d.alu_out   = ex_q.alu_out;
        wb_d.mem_rdata = (state_q == st_access) ? prdata_i : '0;
        wb_d.pc        = ex_q.pc;
        wb_d.u_imm     = ex_q.u_imm;
        wb_d.br_en     = ex_q.br_en;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= st_idle;
            ready_q    <= 1'b0;
            pend_q     <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            ready_q    <= 1'b1;
            pend_q     <= accept && !is_mem;
            wb_valid_q <= wb_load;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ex_q <= ex_data_i;
        end
        if (wb_load) begin
            wb_q <= wb_d;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_data_o  = wb_q;

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
    import rv32i_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic we_i,
    input  reg_addr_t rd_i,
    input  rv32i_word wdata_i,
    input  reg_addr_t rs_addr_i,
    output rv32i_word rs_data_o
);

    rv32i_word regs [num_regs];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            // x0 is never written and stays zero
            regs[rd_i] <= wdata_i;
        end
    end

    // async read without same-cycle bypass
    assign rs_data_o = regs[rs_addr_i];

endmodule

`default_nettype wire

// File: rtl/rv32i_backend.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_backend
    import rv32i_pkg::*;
#(
    parameter logic [7:0] WAIT_CYCLES = 8'd1
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic ex_valid_i,
    input  ex_mem_t   ex_data_i,
    output logic      ex_ready_o,
    input  reg_addr_t rs_addr_i,
    output rv32i_word rs_data_o,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output rv32i_word wb_data_o
);

    apb_req_t  apb;
    rv32i_word prdata;
    logic      pready;
    logic      wb_valid;
    mem_wb_t   wb_data;

    mem_stage u_mem_stage (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ex_valid_i (ex_valid_i),
        .ex_data_i  (ex_data_i),
        .ex_ready_o (ex_ready_o),
        .apb_o      (apb),
        .prdata_i   (prdata),
        .pready_i   (pready),
        .wb_valid_o (wb_valid),
        .wb_data_o  (wb_data)
    );

    data_ram #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_data_ram (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .apb_i    (apb),
        .prdata_o (prdata),
        .pready_o (pready)
    );

    // register file write doubles as the observation port
    wb_stage u_wb_stage (
        .wb_valid_i (wb_valid),
        .wb_data_i  (wb_data),
        .rf_we_o    (wb_valid_o),
        .rf_rd_o    (wb_rd_o),
        .rf_wdata_o (wb_data_o)
    );

    regfile u_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (wb_valid_o),
        .rd_i      (wb_rd_o),
        .wdata_i   (wb_data_o),
        .rs_addr_i (rs_addr_i),
        .rs_data_o (rs_data_o)
    );

endmodule

`default_nettype wire

// File: rtl/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    // data path width
    localparam int unsigned xlen = 32;

    // architectural registers
    localparam int unsigned num_regs = 32;

    // data ram geometry with one word per entry
    localparam int unsigned ram_words = 256;
    localparam int unsigned ram_idx_w = $clog2(ram_words);

    typedef logic [xlen-1:0] rv32i_word;
    typedef logic [4:0]      reg_addr_t;

    // writeback source
    typedef enum logic [3:0] {
        alu_out,
        br_en,
        u_imm,
        lw,
        pc_plus4,
        lb,
        lbu,
        lh,
        lhu
    } regfilemux_sel_t;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_t;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_t;

    typedef struct packed {
        logic            load_regfile;
        regfilemux_sel_t regfilemux_sel;
        mem_op_t         mem_op;
        mem_size_t       mem_size;
    } ctrl_word_t;

    // executed instruction from upstream
    typedef struct packed {
        ctrl_word_t ctrl;
        reg_addr_t  rd;
        rv32i_word  alu_out;
        rv32i_word  store_data;
        rv32i_word  pc;
        rv32i_word  u_imm;
        logic       br_en;
    } ex_mem_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        reg_addr_t  rd;
        rv32i_word  alu_out;
        rv32i_word  mem_rdata;
        rv32i_word  pc;
        rv32i_word  u_imm;
        logic       br_en;
    } mem_wb_t;

    // master side of the apb link
    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        rv32i_word  paddr;
        rv32i_word  pwdata;
        logic [3:0] pstrb;
    } apb_req_t;

endpackage

`default_nettype wire

// File: rtl/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage
    import rv32i_pkg::*;
(
    input  wire logic wb_valid_i,
    input  mem_wb_t   wb_data_i,
    output logic      rf_we_o,
    output reg_addr_t rf_rd_o,
    output rv32i_word rf_wdata_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    rv32i_word   rdata;

    assign rdata   = wb_data_i.mem_rdata;
    assign rf_we_o = wb_valid_i && wb_data_i.ctrl.load_regfile;
    assign rf_rd_o = wb_data_i.rd;

    // lane pick from the low address bits
    always_comb begin
        case (wb_data_i.alu_out[1:0])
            2'b00:   byte_lane = rdata[7:0];
            2'b01:   byte_lane = rdata[15:8];
            2'b10:   byte_lane = rdata[23:16];
            default: byte_lane = rdata[31:24];
        endcase
        // bit 0 ignored for halfwords
        if (wb_data_i.alu_out[1]) begin
            half_lane = rdata[31:16];
        end else begin
            half_lane = rdata[15:0];
        end
    end

    always_comb begin
        unique case (wb_data_i.ctrl.regfilemux_sel)
            alu_out: begin
                rf_wdata_o = wb_data_i.alu_out;
            end
            br_en: begin
                rf_wdata_o = {{(xlen-1){1'b0}}, wb_data_i.br_en};
            end
            u_imm: begin
                rf_wdata_o = wb_data_i.u_imm;
            end
            pc_plus4: begin
                rf_wdata_o = wb_data_i.pc + 32'd4;
            end
            lw: begin
                rf_wdata_o = rdata;
            end
            lb: begin
                rf_wdata_o = {{24{byte_lane[7]}}, byte_lane};
            end
            lbu: begin
                rf_wdata_o = {24'h0, byte_lane};
            end
            lh: begin
                rf_wdata_o = {{16{half_lane[15]}}, half_lane};
            end
            lhu: begin
                rf_wdata_o = {16'h0, half_lane};
            end
            default: begin
                rf_wdata_o = wb_data_i.alu_out;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rv32i_backend.f
rtl/rv32i_pkg.sv
rtl/mem_stage.sv
rtl/data_ram.sv
rtl/wb_stage.sv
rtl/regfile.sv
rtl/rv32i_backend.sv
bench/backend_props.sv
bench/backend_checker.sv
bench/tb_rv32i_backend.sv
